// ==== hw/riscv_core_defines.svh ====
/*
 * RV32I width macros shared by the package and the RTL.
 * Values are fixed by the ISA, so changing them is not supported.
 */

`ifndef RISCV_CORE_DEFINES_SVH
`define RISCV_CORE_DEFINES_SVH

// Data path width
`define RV_XLEN     32
// Architectural register count, x0 included
`define RV_NUM_REGS 32
// Register index width
`define RV_REG_AW   5
// Shift amount field width, low bits of operand B
`define RV_SHAMT_W  5

`endif

// ==== hw/riscv_core_pkg.sv ====
/*
 * Shared types for the RV32I integer pipeline.
 * Only OP, OP-IMM and LUI opcodes are defined here.
 * ALU op encodings are internal and not tied to any ISA field.
 */

`default_nettype none

`include "riscv_core_defines.svh"

package riscv_core_pkg;

    // One data word
    typedef logic [`RV_XLEN-1:0]   word_t;
    // Register file index
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;
    // Major opcode, instr[6:0]
    typedef logic [6:0]            opcode_t;

    // Major opcodes in use
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_OP_ADD  = 4'd0,
        ALU_OP_SUB  = 4'd1,
        ALU_OP_XOR  = 4'd2,
        ALU_OP_OR   = 4'd3,
        ALU_OP_AND  = 4'd4,
        ALU_OP_SLL  = 4'd5,
        ALU_OP_SRL  = 4'd6,
        ALU_OP_SRA  = 4'd7,
        ALU_OP_SLT  = 4'd8,
        ALU_OP_SLTU = 4'd9,
        // Operand B passes straight through
        ALU_OP_LUI  = 4'd10
    } alu_op_e;

endpackage : riscv_core_pkg

`default_nettype wire

// ==== hw/regfile.sv ====
/*
 * 32 x 32-bit register file, two async read ports, one write port.
 * Reads are combinational; a write shows up the cycle after its edge.
 * Writes to x0 are dropped, so x0 always reads zero.
 */

`default_nettype none

`include "riscv_core_defines.svh"

module regfile (
    input  wire                        clk_i,
    input  wire                        arst_n_i,
    input  riscv_core_pkg::reg_addr_t  raddr_a_i,
    input  riscv_core_pkg::reg_addr_t  raddr_b_i,
    output riscv_core_pkg::word_t      rdata_a_o,
    output riscv_core_pkg::word_t      rdata_b_o,
    input  logic                       we_i,
    input  riscv_core_pkg::reg_addr_t  waddr_i,
    input  riscv_core_pkg::word_t      wdata_i
);

    import riscv_core_pkg::*;

    // Register array, x0 included
    word_t regs [`RV_NUM_REGS];

    // Whole array clears on reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Combinational read ports
    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule : regfile

`default_nettype wire

// ==== hw/decode_stage.sv ====
/*
 * Decode stage: field split, immediates, operand forwarding.
 * Forward priority is execute, then writeback, then register file.
 * No stalls; a new instruction may be accepted every cycle.
 */

`default_nettype none

`include "riscv_core_defines.svh"

module decode_stage (
    input  wire                        clk_i,
    input  wire                        arst_n_i,
    input  logic                       instr_valid_i,
    input  riscv_core_pkg::word_t      instr_i,
    output riscv_core_pkg::reg_addr_t  rs1_addr_o,
    output riscv_core_pkg::reg_addr_t  rs2_addr_o,
    input  riscv_core_pkg::word_t      rs1_data_i,
    input  riscv_core_pkg::word_t      rs2_data_i,
    input  logic                       ex_fwd_we_i,
    input  riscv_core_pkg::reg_addr_t  ex_fwd_rd_i,
    input  riscv_core_pkg::word_t      ex_fwd_data_i,
    input  logic                       wb_fwd_we_i,
    input  riscv_core_pkg::reg_addr_t  wb_fwd_rd_i,
    input  riscv_core_pkg::word_t      wb_fwd_data_i,
    output logic                       dec_valid_o,
    output logic                       dec_we_o,
    output logic                       dec_illegal_o,
    output riscv_core_pkg::alu_op_e    dec_op_o,
    output riscv_core_pkg::word_t      dec_a_o,
    output riscv_core_pkg::word_t      dec_b_o,
    output riscv_core_pkg::reg_addr_t  dec_rd_o
);

    import riscv_core_pkg::*;

    opcode_t    opcode;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    alu_op_e    op_sel;
    logic       legal;
    word_t      src_a;
    word_t      src_b;

    // Newest value of a source register
    function automatic word_t fwd_operand(input reg_addr_t addr, input word_t rf_data);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd_we_i && (ex_fwd_rd_i == addr)) begin
            val = ex_fwd_data_i;
        end else if (wb_fwd_we_i && (wb_fwd_rd_i == addr)) begin
            val = wb_fwd_data_i;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    // ============================================================
    // Field split and immediates
    // ============================================================
    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign funct7 = instr_i[31:25];
    // I-type, sign extended from bit 31
    assign imm_i  = {{(`RV_XLEN-12){instr_i[31]}}, instr_i[31:20]};
    // U-type, low 12 bits zero
    assign imm_u  = {instr_i[31:12], 12'b0};

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // ============================================================
    // Operation select and legality
    // ============================================================
    always_comb begin
        // funct3 picks the base op for OP and OP-IMM
        case (funct3)
            3'b000:  op_sel = (opcode == OPC_OP && funct7[5]) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  op_sel = ALU_OP_SLL;
            3'b010:  op_sel = ALU_OP_SLT;
            3'b011:  op_sel = ALU_OP_SLTU;
            3'b100:  op_sel = ALU_OP_XOR;
            3'b101:  op_sel = funct7[5] ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  op_sel = ALU_OP_OR;
            default: op_sel = ALU_OP_AND;
        endcase
        case (opcode)
            OPC_OP: begin
                // Only SUB and SRA may carry funct7 = 0100000
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b001:  legal = (funct7 == 7'b0000000);
                    3'b101:  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    default: legal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                op_sel = ALU_OP_LUI;
                legal  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // Operand A is zero for LUI; B is rs2, I-imm or U-imm
    always_comb begin
        src_a = (opcode == OPC_LUI) ? '0 : fwd_operand(rs1, rs1_data_i);
        src_b = (opcode == OPC_LUI)    ? imm_u :
                (opcode == OPC_OP_IMM) ? imm_i : fwd_operand(rs2, rs2_data_i);
    end

    // ============================================================
    // Decode to execute register
    // ============================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_valid_o   <= 1'b0;
            dec_we_o      <= 1'b0;
            dec_illegal_o <= 1'b0;
        end else begin
            dec_valid_o   <= instr_valid_i;
            dec_we_o      <= instr_valid_i && legal && (rd != '0);
            dec_illegal_o <= instr_valid_i && !legal;
        end
    end

    // Payload, qualified by dec_valid_o downstream
    always_ff @(posedge clk_i) begin
        dec_op_o <= op_sel;
        dec_a_o  <= src_a;
        dec_b_o  <= src_b;
        dec_rd_o <= legal ? rd : '0;
    end

endmodule : decode_stage

`default_nettype wire

// ==== hw/alu.sv ====
/*
 * Combinational RV32I ALU.
 * Shifts use only the low five bits of operand B.
 * Overflow covers ADD and SUB only; unused op codes give zero.
 */

`default_nettype none

`include "riscv_core_defines.svh"

module alu (
    input  riscv_core_pkg::alu_op_e alu_op_i,
    input  riscv_core_pkg::word_t   operand_a_i,
    input  riscv_core_pkg::word_t   operand_b_i,
    output riscv_core_pkg::word_t   alu_result_o,
    output logic                    overflow_o
);

    import riscv_core_pkg::*;

    word_t                  result;
    logic [`RV_SHAMT_W-1:0] shamt;
    logic                   sign_a;
    logic                   sign_b;
    logic                   sign_r;

    assign shamt = operand_b_i[`RV_SHAMT_W-1:0];

    always_comb begin
        case (alu_op_i)
            ALU_OP_ADD:  result = operand_a_i + operand_b_i;
            ALU_OP_SUB:  result = operand_a_i - operand_b_i;
            ALU_OP_XOR:  result = operand_a_i ^ operand_b_i;
            ALU_OP_OR:   result = operand_a_i | operand_b_i;
            ALU_OP_AND:  result = operand_a_i & operand_b_i;
            ALU_OP_SLL:  result = operand_a_i << shamt;
            ALU_OP_SRL:  result = operand_a_i >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_OP_SRA:  result = $signed(operand_a_i) >>> shamt;
            ALU_OP_SLT:  result = ($signed(operand_a_i) < $signed(operand_b_i)) ? word_t'(1) : '0;
            ALU_OP_SLTU: result = (operand_a_i < operand_b_i) ? word_t'(1) : '0;
            // Immediate already placed in operand B by decode
            ALU_OP_LUI:  result = operand_b_i;
            default:     result = '0;
        endcase
    end

    // ============================================================
    // Signed overflow from operand and result signs
    // ============================================================
    assign sign_a = operand_a_i[`RV_XLEN-1];
    assign sign_b = operand_b_i[`RV_XLEN-1];
    assign sign_r = result[`RV_XLEN-1];

    always_comb begin
        case (alu_op_i)
            // Same signs in, opposite sign out
            ALU_OP_ADD: overflow_o = (sign_a == sign_b) && (sign_r != sign_a);
            // Opposite signs in, result takes the subtrahend's sign
            ALU_OP_SUB: overflow_o = (sign_a != sign_b) && (sign_r == sign_b);
            default:    overflow_o = 1'b0;
        endcase
    end

    assign alu_result_o = result;

endmodule : alu

`default_nettype wire

// ==== hw/execute_stage.sv ====
/*
 * Execute stage: ALU plus the writeback register.
 * The raw ALU result is also sent back to decode for forwarding.
 * Illegal instructions write back zero data with no overflow.
 */

`default_nettype none

module execute_stage (
    input  wire                        clk_i,
    input  wire                        arst_n_i,
    input  logic                       dec_valid_i,
    input  logic                       dec_we_i,
    input  logic                       dec_illegal_i,
    input  riscv_core_pkg::alu_op_e    dec_op_i,
    input  riscv_core_pkg::word_t      dec_a_i,
    input  riscv_core_pkg::word_t      dec_b_i,
    input  riscv_core_pkg::reg_addr_t  dec_rd_i,
    output logic                       ex_fwd_we_o,
    output riscv_core_pkg::reg_addr_t  ex_fwd_rd_o,
    output riscv_core_pkg::word_t      ex_fwd_data_o,
    output logic                       wb_valid_o,
    output logic                       wb_we_o,
    output logic                       wb_overflow_o,
    output logic                       wb_illegal_o,
    output riscv_core_pkg::reg_addr_t  wb_rd_o,
    output riscv_core_pkg::word_t      wb_data_o
);

    import riscv_core_pkg::*;

    word_t alu_result;
    logic  alu_overflow;

    alu u_alu (
        .alu_op_i     (dec_op_i),
        .operand_a_i  (dec_a_i),
        .operand_b_i  (dec_b_i),
        .alu_result_o (alu_result),
        .overflow_o   (alu_overflow)
    );

    // Forward path to decode, same cycle
    assign ex_fwd_we_o   = dec_valid_i && dec_we_i;
    assign ex_fwd_rd_o   = dec_rd_i;
    assign ex_fwd_data_o = alu_result;

    // Writeback register; payload holds until the next valid op
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o    <= 1'b0;
            wb_we_o       <= 1'b0;
            wb_overflow_o <= 1'b0;
            wb_illegal_o  <= 1'b0;
            wb_rd_o       <= '0;
            wb_data_o     <= '0;
        end else begin
            wb_valid_o <= dec_valid_i;
            wb_we_o    <= dec_valid_i && dec_we_i;
            if (dec_valid_i) begin
                wb_overflow_o <= alu_overflow && !dec_illegal_i;
                wb_illegal_o  <= dec_illegal_i;
                wb_rd_o       <= dec_rd_i;
                wb_data_o     <= dec_illegal_i ? '0 : alu_result;
            end
        end
    end

endmodule : execute_stage

`default_nettype wire

// ==== hw/int_pipe_top.sv ====
/*
 * RV32I integer pipe: decode, execute, writeback.
 * Fixed two-cycle latency, in order, no back-pressure.
 * Overflow is reported only and never traps.
 */

`default_nettype none

module int_pipe_top (
    input  wire                        clk_i,
    input  wire                        arst_n_i,
    input  logic                       instr_valid_i,
    input  riscv_core_pkg::word_t      instr_i,
    output logic                       wb_valid_o,
    output riscv_core_pkg::reg_addr_t  wb_rd_o,
    output riscv_core_pkg::word_t      wb_data_o,
    output logic                       wb_overflow_o,
    output logic                       wb_illegal_o
);

    import riscv_core_pkg::*;

    // Register file read
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // Decode to execute
    logic      dec_valid;
    logic      dec_we;
    logic      dec_illegal;
    alu_op_e   dec_op;
    word_t     dec_a;
    word_t     dec_b;
    reg_addr_t dec_rd;

    // Execute forward path
    logic      ex_fwd_we;
    reg_addr_t ex_fwd_rd;
    word_t     ex_fwd_data;

    // Writeback write enable, also the wb forward qualifier
    logic      wb_we;

    decode_stage u_decode (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_fwd_we_i   (ex_fwd_we),
        .ex_fwd_rd_i   (ex_fwd_rd),
        .ex_fwd_data_i (ex_fwd_data),
        .wb_fwd_we_i   (wb_we),
        .wb_fwd_rd_i   (wb_rd_o),
        .wb_fwd_data_i (wb_data_o),
        .dec_valid_o   (dec_valid),
        .dec_we_o      (dec_we),
        .dec_illegal_o (dec_illegal),
        .dec_op_o      (dec_op),
        .dec_a_o       (dec_a),
        .dec_b_o       (dec_b),
        .dec_rd_o      (dec_rd)
    );

    execute_stage u_execute (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .dec_valid_i   (dec_valid),
        .dec_we_i      (dec_we),
        .dec_illegal_i (dec_illegal),
        .dec_op_i      (dec_op),
        .dec_a_i       (dec_a),
        .dec_b_i       (dec_b),
        .dec_rd_i      (dec_rd),
        .ex_fwd_we_o   (ex_fwd_we),
        .ex_fwd_rd_o   (ex_fwd_rd),
        .ex_fwd_data_o (ex_fwd_data),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we),
        .wb_overflow_o (wb_overflow_o),
        .wb_illegal_o  (wb_illegal_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    // Written at the edge after the writeback register loads
    regfile u_regfile (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (rs1_addr),
        .raddr_b_i (rs2_addr),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data),
        .we_i      (wb_we),
        .waddr_i   (wb_rd_o),
        .wdata_i   (wb_data_o)
    );

endmodule : int_pipe_top

`default_nettype wire

// ==== test/int_pipe_asserts.sv ====
/*
 * Assertions for the integer pipe, bound to int_pipe_top.
 * Latency check assumes the fixed two-cycle pipe with no stalls.
 */

`default_nettype none

module int_pipe_asserts (
    input  wire                        clk_i,
    input  wire                        arst_n_i,
    input  logic                       instr_valid_i,
    input  logic                       wb_valid_i,
    input  riscv_core_pkg::reg_addr_t  wb_rd_i,
    input  riscv_core_pkg::word_t      wb_data_i
);

    // No result while reset is held
    a_reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !wb_valid_i)
        else $error("wb_valid high during reset");

    // Every accepted instruction leaves two cycles later
    a_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $past(instr_valid_i, 2) |-> wb_valid_i)
        else $error("result missing two cycles after issue");

    // Result fields fully known when valid
    a_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_i |-> !$isunknown({wb_rd_i, wb_data_i}))
        else $error("unknown bits on wb_rd or wb_data");

endmodule : int_pipe_asserts

bind int_pipe_top int_pipe_asserts u_asserts (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o)
);

`default_nettype wire

// ==== test/int_pipe_tb.sv ====
/*
 * Testbench for the RV32I integer pipe.
 * Expected values are worked out by hand from RV32I semantics.
 * Rows are issued in order with random idle gaps and checked in order.
 */

`default_nettype none

module int_pipe_tb;

    import riscv_core_pkg::*;

    // Major opcodes for the instruction encoders
    localparam logic [6:0] OPCODE_REG = 7'b0110011;
    localparam logic [6:0] OPCODE_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI = 7'b0110111;
    // Cycles allowed for one result
    localparam int RESULT_TIMEOUT = 20;

    logic        clk_i;
    logic        arst_n_i;
    logic        instr_valid_i;
    word_t       instr_i;
    logic        wb_valid_o;
    reg_addr_t   wb_rd_o;
    word_t       wb_data_o;
    logic        wb_overflow_o;
    logic        wb_illegal_o;

    // Stimulus table, one entry per instruction
    word_t       tbl_instr[$];
    reg_addr_t   tbl_rd[$];
    word_t       tbl_data[$];
    logic        tbl_ovf[$];
    logic        tbl_ill[$];

    int_pipe_top dut0 (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_overflow_o (wb_overflow_o),
        .wb_illegal_o  (wb_illegal_o)
    );

    always #2 clk_i = ~clk_i;

    // ============================================================
    // Instruction encoders and table helpers
    // ============================================================
    function automatic word_t encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                       input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, OPCODE_REG};
    endfunction

    function automatic word_t encode_i(input logic [2:0] f3, input reg_addr_t rd,
                                       input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPCODE_IMM};
    endfunction

    function automatic word_t encode_u(input reg_addr_t rd, input logic [19:0] imm);
        return {imm, rd, OPCODE_LUI};
    endfunction

    task automatic add_row(input word_t instr, input reg_addr_t rd, input word_t data,
                           input logic ovf, input logic ill);
        tbl_instr.push_back(instr);
        tbl_rd.push_back(rd);
        tbl_data.push_back(data);
        tbl_ovf.push_back(ovf);
        tbl_ill.push_back(ill);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s got 0x%08h expected 0x%08h",
                     $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic build_table();
        // First op reads reset registers
        add_row(encode_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h0000_0000, 1'b0, 1'b0);
        // Immediates: ADDI -5, ORI, XORI, ANDI, LUI, XORI -1
        add_row(encode_i(3'b000, 5'd1, 5'd0, 12'hFFB), 5'd1, 32'hFFFF_FFFB, 1'b0, 1'b0);
        add_row(encode_i(3'b110, 5'd2, 5'd0, 12'h0F0), 5'd2, 32'h0000_00F0, 1'b0, 1'b0);
        add_row(encode_i(3'b100, 5'd4, 5'd1, 12'h0FF), 5'd4, 32'hFFFF_FF04, 1'b0, 1'b0);
        add_row(encode_i(3'b111, 5'd5, 5'd4, 12'h7F0), 5'd5, 32'h0000_0700, 1'b0, 1'b0);
        add_row(encode_u(5'd6, 20'h80000), 5'd6, 32'h8000_0000, 1'b0, 1'b0);
        add_row(encode_i(3'b100, 5'd7, 5'd6, 12'hFFF), 5'd7, 32'h7FFF_FFFF, 1'b0, 1'b0);
        add_row(encode_i(3'b000, 5'd8, 5'd0, 12'h001), 5'd8, 32'h0000_0001, 1'b0, 1'b0);
        // Overflow on ADD and SUB, none on a mixed-sign ADD
        add_row(encode_r(7'h00, 3'b000, 5'd9, 5'd7, 5'd8), 5'd9, 32'h8000_0000, 1'b1, 1'b0);
        add_row(encode_r(7'h20, 3'b000, 5'd10, 5'd6, 5'd8), 5'd10, 32'h7FFF_FFFF, 1'b1, 1'b0);
        add_row(encode_r(7'h00, 3'b000, 5'd11, 5'd1, 5'd2), 5'd11, 32'h0000_00EB, 1'b0, 1'b0);
        // Shift amount 36, only the low five bits count
        add_row(encode_i(3'b000, 5'd12, 5'd0, 12'h024), 5'd12, 32'h0000_0024, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b001, 5'd13, 5'd2, 5'd12), 5'd13, 32'h0000_0F00, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b101, 5'd14, 5'd1, 5'd12), 5'd14, 32'h0FFF_FFFF, 1'b0, 1'b0);
        add_row(encode_r(7'h20, 3'b101, 5'd15, 5'd1, 5'd12), 5'd15, 32'hFFFF_FFFF, 1'b0, 1'b0);
        add_row(encode_r(7'h20, 3'b101, 5'd16, 5'd6, 5'd8), 5'd16, 32'hC000_0000, 1'b0, 1'b0);
        // SLLI, SRLI, SRAI
        add_row(encode_i(3'b001, 5'd17, 5'd8, 12'h01F), 5'd17, 32'h8000_0000, 1'b0, 1'b0);
        add_row(encode_i(3'b101, 5'd18, 5'd6, 12'h01F), 5'd18, 32'h0000_0001, 1'b0, 1'b0);
        add_row(encode_i(3'b101, 5'd19, 5'd6, 12'h404), 5'd19, 32'hF800_0000, 1'b0, 1'b0);
        // Signed and unsigned compares of -5 against 1
        add_row(encode_r(7'h00, 3'b010, 5'd20, 5'd1, 5'd8), 5'd20, 32'h0000_0001, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b011, 5'd21, 5'd1, 5'd8), 5'd21, 32'h0000_0000, 1'b0, 1'b0);
        add_row(encode_i(3'b010, 5'd22, 5'd1, 12'h000), 5'd22, 32'h0000_0001, 1'b0, 1'b0);
        add_row(encode_i(3'b011, 5'd23, 5'd8, 12'hFFF), 5'd23, 32'h0000_0001, 1'b0, 1'b0);
        // Dependent chain on x24
        add_row(encode_i(3'b000, 5'd24, 5'd0, 12'h003), 5'd24, 32'h0000_0003, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b000, 5'd24, 5'd24, 5'd24), 5'd24, 32'h0000_0006, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b000, 5'd24, 5'd24, 5'd24), 5'd24, 32'h0000_000C, 1'b0, 1'b0);
        add_row(encode_r(7'h20, 3'b000, 5'd25, 5'd24, 5'd8), 5'd25, 32'h0000_000B, 1'b0, 1'b0);
        // Write to x0 reports its result, x0 still reads zero
        add_row(encode_i(3'b000, 5'd0, 5'd8, 12'h005), 5'd0, 32'h0000_0006, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b000, 5'd26, 5'd0, 5'd8), 5'd26, 32'h0000_0001, 1'b0, 1'b0);
        // Unknown opcode, then SLLI with a bad funct7
        add_row(32'hFFFF_FFFF, 5'd0, 32'h0000_0000, 1'b0, 1'b1);
        add_row(encode_i(3'b001, 5'd1, 5'd1, 12'h401), 5'd0, 32'h0000_0000, 1'b0, 1'b1);
        // x1 and x31 untouched by the illegal ops
        add_row(encode_r(7'h00, 3'b000, 5'd27, 5'd1, 5'd0), 5'd27, 32'hFFFF_FFFB, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b000, 5'd28, 5'd31, 5'd0), 5'd28, 32'h0000_0000, 1'b0, 1'b0);
        // Logic ops keep overflow clear
        add_row(encode_r(7'h00, 3'b110, 5'd29, 5'd2, 5'd6), 5'd29, 32'h8000_00F0, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b111, 5'd30, 5'd1, 5'd2), 5'd30, 32'h0000_00F0, 1'b0, 1'b0);
        add_row(encode_r(7'h00, 3'b100, 5'd31, 5'd1, 5'd8), 5'd31, 32'hFFFF_FFFA, 1'b0, 1'b0);
    endtask

    // ============================================================
    // Stimulus and result collection
    // ============================================================
    task automatic drive_rows();
        int unsigned gap;
        for (int i = 0; i < tbl_instr.size(); i++) begin
            gap = $urandom_range(2, 0);
            // Idle cycles carry junk on instr_i
            repeat (gap) begin
                @(posedge clk_i);
                #1;
                instr_valid_i = 1'b0;
                instr_i       = $urandom();
            end
            @(posedge clk_i);
            #1;
            instr_valid_i = 1'b1;
            instr_i       = tbl_instr[i];
        end
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
    endtask

    task automatic collect_results();
        int waited;
        for (int i = 0; i < tbl_instr.size(); i++) begin
            waited = 0;
            @(negedge clk_i);
            while (wb_valid_o !== 1'b1) begin
                if (waited == RESULT_TIMEOUT) begin
                    $display("ERROR: the result of row %0d never arrived", i);
                    $display("=== FAIL ===");
                    $fatal(1, "result timeout");
                end
                waited++;
                @(negedge clk_i);
            end
            check_value($sformatf("row %0d rd", i), 32'(wb_rd_o), 32'(tbl_rd[i]));
            check_value($sformatf("row %0d data", i), wb_data_o, tbl_data[i]);
            check_value($sformatf("row %0d overflow", i), 32'(wb_overflow_o), 32'(tbl_ovf[i]));
            check_value($sformatf("row %0d illegal", i), 32'(wb_illegal_o), 32'(tbl_ill[i]));
        end
    endtask

    initial begin
        void'($urandom(19));
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        build_table();
        // Reset for 8 cycles, no result may appear
        repeat (8) begin
            @(negedge clk_i);
            check_value("wb_valid in reset", 32'(wb_valid_o), 32'd0);
        end
        @(posedge clk_i);
        #1;
        arst_n_i = 1'b1;
        // Still quiet before the first instruction
        repeat (3) begin
            @(negedge clk_i);
            check_value("wb_valid after reset", 32'(wb_valid_o), 32'd0);
        end
        fork
            drive_rows();
            collect_results();
        join
        // No stray results after the last row
        repeat (4) begin
            @(negedge clk_i);
            check_value("wb_valid after last row", 32'(wb_valid_o), 32'd0);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule : int_pipe_tb

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/riscv_core_pkg.sv
hw/regfile.sv
hw/decode_stage.sv
hw/alu.sv
hw/execute_stage.sv
hw/int_pipe_top.sv
test/int_pipe_asserts.sv
test/int_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the integer pipe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module int_pipe_tb -o Vint_pipe_tb

# Pass only if the testbench printed its pass line
out=$(./obj_dir/Vint_pipe_tb 2>&1 || true)
echo "$out"
echo "$out" | grep -q "^=== PASS ===$"
